// ==== Bender.yml ====
package:
  name: cdc_mux

sources:
  - include_dirs:
      - source
    files:
      - source/cdc_pkg.sv
      - source/gray_ptr.sv
      - source/async_lane_fifo.sv
      - source/lane_dispatch.sv
      - source/lane_collect.sv
      - source/cdc_mux_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - tests/cdc_mux_properties.sv
      - tests/cdc_mux_checker.sv
      - tests/cdc_mux_tb.sv

// ==== all.f ====
+incdir+source
source/cdc_pkg.sv
source/gray_ptr.sv
source/async_lane_fifo.sv
source/lane_dispatch.sv
source/lane_collect.sv
source/cdc_mux_top.sv
tests/cdc_mux_properties.sv
tests/cdc_mux_checker.sv
tests/cdc_mux_tb.sv

// ==== source/async_lane_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cdc_cfg.svh"

module async_lane_fifo (
   input  wire logic                   wclk,
   input  wire logic                   rclk,
   input  wire logic                   rst,
   input  wire logic                   wr_en,
   input  wire logic [`CDC_DATA_W-1:0] wr_data,
   output logic                        full,
   input  wire logic                   rd_en,
   output logic [`CDC_DATA_W-1:0]      rd_data,
   output logic                        empty
);

   localparam int PTR_W = `CDC_ADDR_W + 1;
   localparam int DEPTH = 1 << `CDC_ADDR_W;

   logic [`CDC_DATA_W-1:0] mem [DEPTH];

   // write side
   logic [PTR_W-1:0] wbin;
   logic [PTR_W-1:0] wgray;
   logic [PTR_W-1:0] rgray_s1;
   logic [PTR_W-1:0] rgray_s2;
   logic [PTR_W-1:0] w_level;

   // read side
   logic [PTR_W-1:0] rbin;
   logic [PTR_W-1:0] rgray;
   logic [PTR_W-1:0] wgray_s1;
   logic [PTR_W-1:0] wgray_s2;
   logic [PTR_W-1:0] r_level;

   function automatic logic [PTR_W-1:0] gray2bin(input logic [PTR_W-1:0] g);
      logic [PTR_W-1:0] b;
      b[PTR_W-1] = g[PTR_W-1];
      for (int i = PTR_W - 2; i >= 0; i--) begin
         b[i] = g[i] ^ b[i+1];
      end
      return b;
   endfunction

   gray_ptr wptr_i (
      .wclk (wclk),
      .rst  (rst),
      .inc  (wr_en),
      .bin  (wbin),
      .gray (wgray)
   );

   gray_ptr rptr_i (
      .wclk (rclk),
      .rst  (rst),
      .inc  (rd_en),
      .bin  (rbin),
      .gray (rgray)
   );

   // memory write, enables are trusted
   always_ff @(posedge wclk) begin
      if (wr_en) begin
         mem[wbin[`CDC_ADDR_W-1:0]] <= wr_data;
      end
   end

   // registered read port
   always_ff @(posedge rclk) begin
      if (rd_en) begin
         rd_data <= mem[rbin[`CDC_ADDR_W-1:0]];
      end
   end

   // read pointer into wclk domain
   always_ff @(posedge wclk or posedge rst) begin
      if (rst) begin
         rgray_s1 <= '0;
         rgray_s2 <= '0;
      end else begin
         rgray_s1 <= rgray;
         rgray_s2 <= rgray_s1;
      end
   end

   // write pointer into rclk domain
   always_ff @(posedge rclk or posedge rst) begin
      if (rst) begin
         wgray_s1 <= '0;
         wgray_s2 <= '0;
      end else begin
         wgray_s1 <= wgray;
         wgray_s2 <= wgray_s1;
      end
   end

   // one slot always kept free
   assign w_level = wbin - gray2bin(rgray_s2);
   assign full    = (w_level == PTR_W'(DEPTH - 1));

   assign r_level = gray2bin(wgray_s2) - rbin;
   assign empty   = (r_level == '0);

endmodule

`default_nettype wire

// ==== source/cdc_cfg.svh ====
`ifndef CDC_CFG_SVH
`define CDC_CFG_SVH

// width of one payload word
`define CDC_DATA_W 16

// number of fifo lanes
`define CDC_LANES 4

// lane index width, must cover CDC_LANES
`define CDC_LANE_W 2

// lane fifo address width, 8 entries per lane
`define CDC_ADDR_W 3

`endif

// ==== source/cdc_mux_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cdc_cfg.svh"

module cdc_mux_top
   import cdc_pkg::*;
(
   input  wire logic       wclk,
   input  wire logic       rclk,
   input  wire logic       rst,
   input  wire lane_word_t in_word,
   input  wire logic       in_valid,
   output lane_word_t      out_word,
   output logic            out_valid,
   output logic [15:0]     drop_count
);

   logic [`CDC_LANES-1:0]                  lane_full;
   logic [`CDC_LANES-1:0]                  lane_empty;
   logic [`CDC_LANES-1:0]                  wr_en;
   logic [`CDC_LANES-1:0]                  rd_en;
   logic [`CDC_DATA_W-1:0]                 wr_data;
   logic [`CDC_LANES-1:0][`CDC_DATA_W-1:0] lane_data;

   lane_dispatch dispatch_i (
      .wclk       (wclk),
      .rst        (rst),
      .in_word    (in_word),
      .in_valid   (in_valid),
      .lane_full  (lane_full),
      .wr_en      (wr_en),
      .wr_data    (wr_data),
      .drop_count (drop_count)
   );

   // one fifo per lane, write data shared
   for (genvar g = 0; g < `CDC_LANES; g++) begin : g_lane
      async_lane_fifo lane_i (
         .wclk    (wclk),
         .rclk    (rclk),
         .rst     (rst),
         .wr_en   (wr_en[g]),
         .wr_data (wr_data),
         .full    (lane_full[g]),
         .rd_en   (rd_en[g]),
         .rd_data (lane_data[g]),
         .empty   (lane_empty[g])
      );
   end

   lane_collect collect_i (
      .rclk       (rclk),
      .rst        (rst),
      .lane_empty (lane_empty),
      .rd_en      (rd_en),
      .lane_data  (lane_data),
      .out_word   (out_word),
      .out_valid  (out_valid)
   );

endmodule

`default_nettype wire

// ==== source/cdc_pkg.sv ====
`default_nettype none

`include "cdc_cfg.svh"

package cdc_pkg;

   // lane index
   typedef logic [`CDC_LANE_W-1:0] lane_t;

   // data word tagged with its lane
   typedef struct packed {
      lane_t                  lane;
      logic [`CDC_DATA_W-1:0] data;
   } lane_word_t;

   // collector fsm states
   typedef enum logic {
      COL_SCAN,
      COL_FETCH
   } collect_state_t;

endpackage

`default_nettype wire

// ==== source/gray_ptr.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cdc_cfg.svh"

module gray_ptr (
   input  wire logic                 wclk,
   input  wire logic                 rst,
   input  wire logic                 inc,
   output logic [`CDC_ADDR_W:0]      bin,
   output logic [`CDC_ADDR_W:0]      gray
);

   logic [`CDC_ADDR_W:0] bin_next;

   // one extra wrap bit above the address
   assign bin_next = bin + 1'b1;

   always_ff @(posedge wclk or posedge rst) begin
      if (rst) begin
         bin  <= '0;
         gray <= '0;
      end else if (inc) begin
         bin  <= bin_next;
         // gray code of the new count
         gray <= bin_next ^ (bin_next >> 1);
      end
   end

endmodule

`default_nettype wire

// ==== source/lane_collect.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cdc_cfg.svh"

module lane_collect
   import cdc_pkg::*;
(
   input  wire logic                                   rclk,
   input  wire logic                                   rst,
   input  wire logic [`CDC_LANES-1:0]                  lane_empty,
   output logic [`CDC_LANES-1:0]                       rd_en,
   input  wire logic [`CDC_LANES-1:0][`CDC_DATA_W-1:0] lane_data,
   output lane_word_t                                  out_word,
   output logic                                        out_valid
);

   collect_state_t state;
   lane_t          next_lane;
   lane_t          fetch_lane;
   lane_t          pick;
   logic           found;

   // first non-empty lane starting at the round-robin candidate
   always_comb begin
      int unsigned idx;
      found = 1'b0;
      pick  = '0;
      for (int i = 0; i < `CDC_LANES; i++) begin
         idx = (int'(next_lane) + i) % `CDC_LANES;
         if (!found && !lane_empty[idx]) begin
            found = 1'b1;
            pick  = lane_t'(idx);
         end
      end
   end

   // single read strobe, only while scanning
   always_comb begin
      rd_en = '0;
      if (state == COL_SCAN && found) begin
         rd_en[pick] = 1'b1;
      end
   end

   always_ff @(posedge rclk or posedge rst) begin
      if (rst) begin
         state      <= COL_SCAN;
         next_lane  <= '0;
         fetch_lane <= '0;
      end else begin
         case (state)
            COL_SCAN: begin
               if (found) begin
                  state      <= COL_FETCH;
                  fetch_lane <= pick;
                  next_lane  <= lane_t'((int'(pick) + 1) % `CDC_LANES);
               end
            end
            COL_FETCH: begin
               state <= COL_SCAN;
            end
            default: begin
               state <= COL_SCAN;
            end
         endcase
      end
   end

   // lane data is already registered by the fifo
   assign out_valid     = (state == COL_FETCH);
   assign out_word.lane = fetch_lane;
   assign out_word.data = lane_data[fetch_lane];

endmodule

`default_nettype wire

// ==== source/lane_dispatch.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cdc_cfg.svh"

module lane_dispatch
   import cdc_pkg::*;
(
   input  wire logic                   wclk,
   input  wire logic                   rst,
   input  wire lane_word_t             in_word,
   input  wire logic                   in_valid,
   input  wire logic [`CDC_LANES-1:0]  lane_full,
   output logic [`CDC_LANES-1:0]       wr_en,
   output logic [`CDC_DATA_W-1:0]      wr_data,
   output logic [15:0]                 drop_count
);

   lane_word_t            word_q;
   logic                  valid_q;
   logic [`CDC_LANES-1:0] lane_sel;
   logic                  drop;

   // input stage
   always_ff @(posedge wclk or posedge rst) begin
      if (rst) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= in_valid;
      end
   end

   always_ff @(posedge wclk) begin
      if (in_valid) begin
         word_q <= in_word;
      end
   end

   // one-hot lane decode
   always_comb begin
      lane_sel = '0;
      lane_sel[word_q.lane] = valid_q;
   end

   assign wr_en   = lane_sel & ~lane_full;
   assign wr_data = word_q.data;
   // word aimed at a full lane
   assign drop    = valid_q && lane_full[word_q.lane];

   // saturating drop counter
   always_ff @(posedge wclk or posedge rst) begin
      if (rst) begin
         drop_count <= '0;
      end else if (drop && (drop_count != '1)) begin
         drop_count <= drop_count + 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== tests/cdc_mux_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cdc_cfg.svh"

module cdc_mux_checker
   import cdc_pkg::*;
(
   input  wire logic       wclk,
   input  wire logic       rclk,
   input  wire logic       rst,
   input  wire lane_word_t in_word,
   input  wire logic       in_valid,
   input  wire lane_word_t out_word,
   input  wire logic       out_valid,
   output int              in_count,
   output int              out_count,
   output int              discard_count,
   output int              pending_count,
   output int              error_count
);

   // expected data per lane, oldest first
   logic [`CDC_DATA_W-1:0] exp_q [`CDC_LANES][$];

   int n_in   = 0;
   int n_out  = 0;
   int n_pop  = 0;
   int n_disc = 0;
   int n_err  = 0;

   assign in_count      = n_in;
   assign out_count     = n_out;
   assign discard_count = n_disc;
   assign pending_count = n_in - n_pop;
   assign error_count   = n_err;

   // inputs change on the falling edge
   always @(posedge wclk) begin
      if (!rst && in_valid) begin
         exp_q[in_word.lane].push_back(in_word.data);
         n_in++;
      end
   end

   // entries ahead of the matching one were dropped by the DUT
   task automatic match_output(input lane_word_t w);
      logic [`CDC_DATA_W-1:0] first;
      logic [`CDC_DATA_W-1:0] head;
      bit                     matched;
      matched = 1'b0;
      if (exp_q[w.lane].size() == 0) begin
         n_err++;
         $display("t=%0t: output on lane %0d while no word is pending there", $time, w.lane);
      end else begin
         first = exp_q[w.lane][0];
         while (!matched && exp_q[w.lane].size() > 0) begin
            head = exp_q[w.lane].pop_front();
            n_pop++;
            if (head == w.data) begin
               matched = 1'b1;
            end else begin
               n_disc++;
            end
         end
         if (!matched) begin
            n_err++;
            $display("FAIL t=%0t out_word.data (lane %0d) expected %h actual %h",
                     $time, w.lane, first, w.data);
         end
      end
   endtask

   always @(negedge rclk) begin
      if (out_valid) begin
         n_out++;
         match_output(out_word);
      end
   end

endmodule

`default_nettype wire

// ==== tests/cdc_mux_properties.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cdc_cfg.svh"

module cdc_mux_properties #(
   parameter int N         = 1,
   parameter bit FIFO_SIDE = 1'b1
) (
   input wire logic         wclk,
   input wire logic         rclk,
   input wire logic         rst,
   input wire logic [N-1:0] wr_en,
   input wire logic [N-1:0] full,
   input wire logic [N-1:0] rd_en,
   input wire logic [N-1:0] empty,
   input wire logic         out_valid
);

   int w_fails = 0;
   int r_fails = 0;
   int fail_count;

   assign fail_count = w_fails + r_fails;

   if (FIFO_SIDE) begin : g_fifo
      // the lane trusts its enables
      no_write_when_full: assert property (
         @(posedge wclk) disable iff (rst) (wr_en & full) == '0)
         else begin
            w_fails++;
            $error("write strobe while lane is full");
         end

      no_read_when_empty: assert property (
         @(posedge rclk) disable iff (rst) (rd_en & empty) == '0)
         else begin
            r_fails++;
            $error("read strobe while lane is empty");
         end
   end else begin : g_collect
      // collector serves one lane per cycle
      single_read: assert property (@(posedge rclk) disable iff (rst) $onehot0(rd_en))
         else begin
            r_fails++;
            $error("more than one read strobe at a time");
         end

      no_back_to_back: assert property (
         @(posedge rclk) disable iff (rst) out_valid |=> !out_valid)
         else begin
            r_fails++;
            $error("out_valid high in two consecutive cycles");
         end
   end

endmodule

bind async_lane_fifo cdc_mux_properties #(.N(1), .FIFO_SIDE(1'b1)) fifo_props_i (
   .wclk (wclk), .rclk (rclk), .rst (rst),
   .wr_en (wr_en), .full (full), .rd_en (rd_en), .empty (empty),
   .out_valid (1'b0)
);

// read strobes and output strobe of the collector
bind lane_collect cdc_mux_properties #(.N(`CDC_LANES), .FIFO_SIDE(1'b0)) collect_props_i (
   .wclk (rclk), .rclk (rclk), .rst (rst),
   .wr_en ('0), .full ('0), .rd_en (rd_en), .empty (lane_empty),
   .out_valid (out_valid)
);

`default_nettype wire

// ==== tests/cdc_mux_stim.txt ====
# columns: lane (decimal), data (hex), idle wclk cycles after the word
# a gap of 150 or more ends a section
1 a001 10
1 a002 10
1 a003 200
0 b000 4
2 b200 5
1 b100 4
3 b300 6
2 b201 4
0 b001 5
3 b301 4
1 b101 200
3 c000 0
3 c001 0
3 c002 0
3 c003 0
3 c004 0
3 c005 0
3 c006 0
3 c007 0
3 c008 0
3 c009 0
3 c00a 0
3 c00b 0
3 c00c 0
3 c00d 0
3 c00e 0
3 c00f 0
3 c010 0
3 c011 0
3 c012 0
3 c013 200

// ==== tests/cdc_mux_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cdc_cfg.svh"

module cdc_mux_tb
   import cdc_pkg::*;
();

   localparam int    SECTION_GAP  = 150;
   localparam int    SPACED_GAP   = 4;
   localparam int    DRAIN_LIMIT  = 2000;
   localparam int    QUIET_CYCLES = 100;
   localparam string STIM_FILE    = "tests/cdc_mux_stim.txt";

   logic        wclk;
   logic        rclk;
   logic        rst;
   lane_word_t  in_word;
   logic        in_valid;
   lane_word_t  out_word;
   logic        out_valid;
   logic [15:0] drop_count;

   int in_count;
   int out_count;
   int discard_count;
   int pending_count;
   int check_errors;
   int tb_errors = 0;
   int total_in  = 0;
   bit timed_out = 1'b0;
   int lane_assert_errors [`CDC_LANES];

   initial begin
      wclk = 1'b0;
      forever #4 wclk = ~wclk;
   end

   // offset so the two clocks never share an edge
   initial begin
      rclk = 1'b0;
      #1;
      forever #6 rclk = ~rclk;
   end

   cdc_mux_top dut_i (
      .wclk       (wclk),
      .rclk       (rclk),
      .rst        (rst),
      .in_word    (in_word),
      .in_valid   (in_valid),
      .out_word   (out_word),
      .out_valid  (out_valid),
      .drop_count (drop_count)
   );

   cdc_mux_checker checker_i (
      .wclk (wclk), .rclk (rclk), .rst (rst),
      .in_word (in_word), .in_valid (in_valid),
      .out_word (out_word), .out_valid (out_valid),
      .in_count (in_count), .out_count (out_count),
      .discard_count (discard_count), .pending_count (pending_count),
      .error_count (check_errors)
   );

   for (genvar g = 0; g < `CDC_LANES; g++) begin : g_assert
      assign lane_assert_errors[g] = dut_i.g_lane[g].lane_i.fifo_props_i.fail_count;
   end

   function automatic int assert_total();
      int sum;
      sum = dut_i.collect_i.collect_props_i.fail_count;
      for (int i = 0; i < `CDC_LANES; i++) begin
         sum += lane_assert_errors[i];
      end
      return sum;
   endfunction

   task automatic check_idle();
      if (drop_count !== 16'd0) begin
         tb_errors++;
         $display("FAIL t=%0t drop_count expected 0 actual %0d", $time, drop_count);
      end
      if (out_valid !== 1'b0) begin
         tb_errors++;
         $display("FAIL t=%0t out_valid expected 0 actual %b", $time, out_valid);
      end
   endtask

   // called on a falling edge and returns on the next one
   task automatic send_word(input int lane, input logic [`CDC_DATA_W-1:0] data);
      in_word.lane = lane_t'(lane);
      in_word.data = data;
      in_valid     = 1'b1;
      total_in++;
      @(negedge wclk);
      in_valid = 1'b0;
   endtask

   // every word is either delivered or dropped
   task automatic wait_drain(input int limit);
      int cycles;
      cycles = 0;
      while (out_count + int'(drop_count) != total_in && cycles < limit) begin
         @(negedge wclk);
         cycles++;
      end
      if (out_count + int'(drop_count) != total_in) begin
         tb_errors++;
         timed_out = 1'b1;
         $display("timeout: %0d of %0d words neither delivered nor dropped after %0d cycles",
                  total_in - out_count - int'(drop_count), total_in, limit);
      end
   endtask

   initial begin
      int                     fd;
      int                     lane;
      int                     gap;
      int                     drop_base;
      int                     quiet_base;
      int                     total_errors;
      bit                     spaced;
      logic [`CDC_DATA_W-1:0] data;
      string                  line;
      rst      = 1'b1;
      in_valid = 1'b0;
      in_word  = '0;
      repeat (5) begin
         @(negedge wclk);
         check_idle();
      end
      rst = 1'b0;
      repeat (10) begin
         @(negedge wclk);
         check_idle();
      end
      fd = $fopen(STIM_FILE, "r");
      if (fd == 0) begin
         tb_errors++;
         $display("cannot open stimulus file %s", STIM_FILE);
      end else begin
         spaced    = 1'b1;
         drop_base = drop_count;
         while (!timed_out && !$feof(fd)) begin
            if ($fgets(line, fd) > 0 && $sscanf(line, "%d %h %d", lane, data, gap) == 3) begin
               send_word(lane, data);
               // slower than the collector drains so nothing may drop
               if (gap < SPACED_GAP) begin
                  spaced = 1'b0;
               end
               repeat (gap) @(negedge wclk);
               if (gap >= SECTION_GAP) begin
                  wait_drain(DRAIN_LIMIT);
                  if (!timed_out && spaced && int'(drop_count) != drop_base) begin
                     tb_errors++;
                     $display("FAIL t=%0t drop_count expected %0d actual %0d",
                              $time, drop_base, drop_count);
                  end
                  spaced    = 1'b1;
                  drop_base = drop_count;
               end
            end
         end
         $fclose(fd);
         if (!timed_out) begin
            wait_drain(DRAIN_LIMIT);
         end
         if (!timed_out) begin
            quiet_base = out_count;
            repeat (QUIET_CYCLES) @(posedge rclk);
            if (out_count != quiet_base) begin
               tb_errors++;
               $display("out_valid seen %0d times in the quiet period",
                        out_count - quiet_base);
            end
            // leftover and discarded entries are exactly the dropped words
            if (pending_count + discard_count != int'(drop_count)) begin
               tb_errors++;
               $display("FAIL t=%0t drop_count expected %0d actual %0d",
                        $time, pending_count + discard_count, drop_count);
            end
            if (in_count != total_in) begin
               tb_errors++;
               $display("checker saw %0d input words but %0d were sent", in_count, total_in);
            end
         end
      end
      total_errors = check_errors + tb_errors + assert_total();
      $display("errors: checker %0d, testbench %0d, assertions %0d (words %0d, drops %0d)",
               check_errors, tb_errors, assert_total(), total_in, drop_count);
      if (total_errors == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire
